// File: bench/countdown_vectors.txt
// glyph rows 0 to 7 of each digit, one digit per line, msb is the leftmost column
// after the glyphs the phase order as phase codes: 0 red, 1 green, 2 yellow
// digit 0
00 3C 66 66 66 00 66 3C
// digit 1
00 18 38 18 18 00 18 7E
// digit 2
00 3C 66 06 0C 00 30 7E
// digit 3
00 3C 66 0C 06 00 66 3C
// digit 4
00 0C 1C 3C 6C 00 7E 0C
// digit 5
00 7E 60 7C 06 00 66 3C
// phase order, the last entry is the wrap back to red
00
01
02
00

// File: files.f
rtl/matrix_pkg.sv
rtl/countdown_seq.sv
rtl/frame_latch.sv
rtl/matrix_scan.sv
rtl/countdown_display_top.sv
bench/tb_countdown_display.sv

// File: Bender.yml
package:
  name: countdown_display

sources:
  - rtl/matrix_pkg.sv
  - rtl/countdown_seq.sv
  - rtl/frame_latch.sv
  - rtl/matrix_scan.sv
  - rtl/countdown_display_top.sv
  - target: test
    files:
      - bench/tb_countdown_display.sv

// File: bench/tb_countdown_display.sv
`timescale 1ns/100ps
`default_nettype none

module tb_countdown_display;

    localparam int CLK_NS      = 10;
    localparam int FRAME_LEN   = matrix_pkg::ROWS * matrix_pkg::ROW_HOLD;
    localparam int SEQ_STEPS   = 3 * 6;
    localparam int WATCHDOG_NS = SEQ_STEPS * matrix_pkg::STEP_CYCLES * CLK_NS + 2000;

    logic       clk;
    logic       rst;
    logic       run;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;

    // 6 glyphs of 8 rows, then 4 phase codes
    logic [7:0] vectors [0:6*matrix_pkg::ROWS+3];
    logic [7:0] cap_r [0:FRAME_LEN-1];
    logic [7:0] cap_g [0:FRAME_LEN-1];

    integer seed;
    int     freeze_start;
    int     freeze_len;
    int     checks;
    int     row_errs;
    int     col_errs;
    int     seq_errs;
    int     freeze_errs;
    bit     run_prev;

    countdown_display_top uut (
        .clk  (clk),
        .rst  (rst),
        .run  (run),
        .row  (row),
        .colr (colr),
        .colg (colg)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the countdown wrapped back to red");
        $display("Test failed");
        $finish;
    end

    // run stays high apart from one freeze window
    initial
    begin
        run = 1'b1;
        seed = 18918;
        freeze_start = 300 + ($random(seed) & 255);
        freeze_len = 96 + ($random(seed) & 7);
        @(negedge rst);
        repeat (freeze_start) @(posedge clk);
        run <= 1'b0;
        repeat (freeze_len) @(posedge clk);
        run <= 1'b1;
    end

    function automatic logic [7:0] glyph_bits(input logic [2:0] digit, input int r);
        return vectors[digit * matrix_pkg::ROWS + r];
    endfunction

    function automatic logic [7:0] red_plane(input logic [2:0] digit,
                                             input matrix_pkg::phase_t ph, input int r);
        if (ph == matrix_pkg::PH_RED || ph == matrix_pkg::PH_YELLOW)
            return glyph_bits(digit, r);
        return 8'h00;
    endfunction

    function automatic logic [7:0] green_plane(input logic [2:0] digit,
                                               input matrix_pkg::phase_t ph, input int r);
        if (ph == matrix_pkg::PH_GREEN || ph == matrix_pkg::PH_YELLOW)
            return glyph_bits(digit, r);
        return 8'h00;
    endfunction

    // position p in the countdown with 6 digits per phase
    function automatic logic [2:0] step_digit(input int p);
        return matrix_pkg::DIGIT_MAX - 3'(p % 6);
    endfunction

    function automatic matrix_pkg::phase_t step_phase(input int p);
        return matrix_pkg::phase_t'(vectors[6 * matrix_pkg::ROWS + p / 6][1:0]);
    endfunction

    function automatic bit frame_matches(input int p);
        bit ok;
        int r;
        ok = 1'b1;
        for (int i = 0; i < FRAME_LEN; i++)
        begin
            r = i / matrix_pkg::ROW_HOLD;
            if (cap_r[i] !== red_plane(step_digit(p), step_phase(p), r))
                ok = 1'b0;
            if (cap_g[i] !== green_plane(step_digit(p), step_phase(p), r))
                ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic check_row(input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp)
        begin
            row_errs++;
            $display("ERR %0t row got %b exp %b", $time, got, exp);
        end
    endtask

    task automatic check_dark(input logic [7:0] got_r, input logic [7:0] got_g);
        checks++;
        if (got_r !== 8'h00 || got_g !== 8'h00)
        begin
            col_errs++;
            $display("ERR %0t colr/colg got %h/%h exp 00/00", $time, got_r, got_g);
        end
    endtask

    task automatic check_cols(input logic [7:0] got_r, input logic [7:0] got_g,
                              input logic [2:0] digit, input matrix_pkg::phase_t ph,
                              input int r);
        logic [7:0] exp_r;
        logic [7:0] exp_g;
        exp_r = red_plane(digit, ph, r);
        exp_g = green_plane(digit, ph, r);
        checks++;
        if (got_r !== exp_r)
        begin
            col_errs++;
            $display("ERR %0t colr got %h exp %h (digit %0d phase %0d row %0d)",
                     $time, got_r, exp_r, digit, ph, r);
        end
        if (got_g !== exp_g)
        begin
            col_errs++;
            $display("ERR %0t colg got %h exp %h (digit %0d phase %0d row %0d)",
                     $time, got_g, exp_g, digit, ph, r);
        end
    endtask

    // one frame from the negedge after row 0 comes up
    task automatic capture_frame(output bit frozen);
        frozen = 1'b1;
        for (int i = 0; i < FRAME_LEN; i++)
        begin
            @(negedge clk);
            check_row(row, 8'b1 << (i / matrix_pkg::ROW_HOLD));
            cap_r[i] = colr;
            cap_g[i] = colg;
            // the level seen one negedge earlier gates the producer on the edge just gone
            if (run_prev)
                frozen = 1'b0;
            run_prev = run;
        end
    endtask

    initial
    begin
        int  pos;
        int  frames;
        int  freeze_checks;
        int  row_before;
        int  col_before;
        int  total;
        bit  frozen;
        bit  frozen_1;
        bit  moved;

        rst = 1'b1;
        checks = 0;
        row_errs = 0;
        col_errs = 0;
        seq_errs = 0;
        freeze_errs = 0;
        $readmemh("bench/countdown_vectors.txt", vectors);

        // dark during reset and on the cycle after release
        for (int i = 0; i < 8; i++)
        begin
            @(posedge clk);
            if (i == 7)
                rst <= 1'b0;
            @(negedge clk);
            check_row(row, 8'h00);
            check_dark(colr, colg);
        end
        $display("test reset: %0d errors", row_errs + col_errs);

        row_before = row_errs;
        col_before = col_errs;
        pos = 0;
        frames = 0;
        freeze_checks = 0;
        frozen_1 = 1'b0;
        run_prev = 1'b1;
        while (pos < SEQ_STEPS)
        begin
            capture_frame(frozen);
            moved = 1'b0;
            if (!frame_matches(pos))
            begin
                if (frame_matches(pos + 1))
                begin
                    pos++;
                    moved = 1'b1;
                end
                else
                begin
                    seq_errs++;
                    $display("frame %0d at %0t shows neither step %0d nor the next one",
                             frames, $time, pos);
                end
            end
            for (int i = 0; i < FRAME_LEN; i++)
                check_cols(cap_r[i], cap_g[i], step_digit(pos), step_phase(pos),
                           i / matrix_pkg::ROW_HOLD);
            // the producer had no edge to step on since the last latch
            if (frozen_1)
            begin
                freeze_checks++;
                if (moved)
                begin
                    freeze_errs++;
                    $display("frame %0d at %0t changed digit while run was low",
                             frames, $time);
                end
            end
            frozen_1 = frozen;
            frames++;
        end

        $display("test scan: %0d frames, %0d row errors", frames, row_errs - row_before);
        $display("test colours: %0d column errors", col_errs - col_before);
        $display("test sequence: %0d steps, %0d errors", pos, seq_errs);
        if (freeze_checks == 0)
        begin
            freeze_errs++;
            $display("freeze window never covered two whole frames");
        end
        $display("test freeze: run low %0d cycles from cycle %0d, %0d frames held, %0d errors",
                 freeze_len, freeze_start, freeze_checks, freeze_errs);

        total = row_errs + col_errs + seq_errs + freeze_errs;
        $display("summary: 5 tests, %0d checks, %0d errors", checks, total);
        if (total == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/countdown_display_top.sv
`timescale 1ns/100ps
`default_nettype none

module countdown_display_top (
    input  wire        clk,
    input  wire        rst,
    input  wire        run,
    output logic [7:0] row,
    output logic [7:0] colr,
    output logic [7:0] colg
);

    logic [2:0]         next_digit;
    matrix_pkg::phase_t next_phase;
    logic [2:0]         shown_digit;
    matrix_pkg::phase_t shown_phase;
    logic               frame_start;

    countdown_seq u_seq (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .next_digit (next_digit),
        .next_phase (next_phase)
    );

    // holds the digit steady for a whole frame
    frame_latch u_latch (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .next_digit  (next_digit),
        .next_phase  (next_phase),
        .shown_digit (shown_digit),
        .shown_phase (shown_phase)
    );

    matrix_scan u_scan (
        .clk         (clk),
        .rst         (rst),
        .shown_digit (shown_digit),
        .shown_phase (shown_phase),
        .frame_start (frame_start),
        .row         (row),
        .colr        (colr),
        .colg        (colg)
    );

endmodule

`default_nettype wire

// File: rtl/matrix_scan.sv
`timescale 1ns/100ps
`default_nettype none

module matrix_scan (
    input  wire                 clk,
    input  wire                 rst,
    input  wire [2:0]           shown_digit,
    input  matrix_pkg::phase_t  shown_phase,
    output logic                frame_start,
    output logic [7:0]          row,
    output logic [7:0]          colr,
    output logic [7:0]          colg
);

    localparam int HOLD_W = $clog2(matrix_pkg::ROW_HOLD);
    localparam int ROW_W  = $clog2(matrix_pkg::ROWS);

    logic              active;
    logic [HOLD_W-1:0] hold_cnt;
    logic [ROW_W-1:0]  row_idx;
    logic [ROW_W-1:0]  row_next;
    logic              row_done;
    logic              last_row;
    logic              load;
    logic [7:0]        glyph_row;
    logic              red_on;
    logic              green_on;

    assign row_done = (hold_cnt == HOLD_W'(matrix_pkg::ROW_HOLD - 1));
    assign last_row = (row_idx == ROW_W'(matrix_pkg::ROWS - 1));

    // first row comes up on the first edge out of reset
    assign load = !active || row_done;

    assign frame_start = active && row_done && last_row;

    always_comb
    begin
        if (!active || last_row)
            row_next = '0;
        else
            row_next = row_idx + 1'b1;
    end

    // the latch updates on the same edge that loads row 0, which is
    // dark in every glyph, so the old digit there never shows
    always_comb
    begin
        if (shown_digit > matrix_pkg::DIGIT_MAX)
            glyph_row = 8'h00;
        else
            glyph_row = matrix_pkg::GLYPH[shown_digit][row_next];
    end

    always_comb
    begin
        case (shown_phase)
            matrix_pkg::PH_RED:
            begin
                red_on   = 1'b1;
                green_on = 1'b0;
            end
            matrix_pkg::PH_GREEN:
            begin
                red_on   = 1'b0;
                green_on = 1'b1;
            end
            matrix_pkg::PH_YELLOW:
            begin
                red_on   = 1'b1;
                green_on = 1'b1;
            end
            default:
            begin
                red_on   = 1'b0;
                green_on = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            active   <= 1'b0;
            hold_cnt <= '0;
            row_idx  <= '0;
            row      <= '0;
            colr     <= '0;
            colg     <= '0;
        end
        else
        begin
            active <= 1'b1;
            if (load)
            begin
                hold_cnt <= '0;
                row_idx  <= row_next;
                row      <= 8'b1 << row_next;
                colr     <= red_on ? glyph_row : 8'h00;
                colg     <= green_on ? glyph_row : 8'h00;
            end
            else
            begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/frame_latch.sv
`timescale 1ns/100ps
`default_nettype none

module frame_latch (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 frame_start,
    input  wire [2:0]           next_digit,
    input  matrix_pkg::phase_t  next_phase,
    output logic [2:0]          shown_digit,
    output matrix_pkg::phase_t  shown_phase
);

    // the producer may step at any cycle, so its values are only
    // taken between frames and the whole matrix shows one digit
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            shown_digit <= matrix_pkg::DIGIT_MAX;
            shown_phase <= matrix_pkg::PH_RED;
        end
        else if (frame_start)
        begin
            shown_digit <= next_digit;
            shown_phase <= next_phase;
        end
    end

endmodule

`default_nettype wire

// File: rtl/countdown_seq.sv
`timescale 1ns/100ps
`default_nettype none

module countdown_seq (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 run,
    output logic [2:0]          next_digit,
    output matrix_pkg::phase_t  next_phase
);

    localparam int CNT_W = $clog2(matrix_pkg::STEP_CYCLES);

    logic [CNT_W-1:0] cyc_cnt;
    logic             step;

    function automatic matrix_pkg::phase_t phase_after(input matrix_pkg::phase_t ph);
        matrix_pkg::phase_t nxt;
        case (ph)
            matrix_pkg::PH_RED:    nxt = matrix_pkg::PH_GREEN;
            matrix_pkg::PH_GREEN:  nxt = matrix_pkg::PH_YELLOW;
            default:               nxt = matrix_pkg::PH_RED;
        endcase
        return nxt;
    endfunction

    // last cycle of the current digit
    assign step = run && (cyc_cnt == CNT_W'(matrix_pkg::STEP_CYCLES - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cyc_cnt <= '0;
        else if (step)
            cyc_cnt <= '0;
        else if (run)
            cyc_cnt <= cyc_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            next_digit <= matrix_pkg::DIGIT_MAX;
            next_phase <= matrix_pkg::PH_RED;
        end
        else if (step)
        begin
            if (next_digit == 3'd0)
            begin
                // countdown done, start the next colour from the top
                next_digit <= matrix_pkg::DIGIT_MAX;
                next_phase <= phase_after(next_phase);
            end
            else
            begin
                next_digit <= next_digit - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/matrix_pkg.sv
`default_nettype none

package matrix_pkg;

    // colour of the current countdown, yellow lights both colour planes
    typedef enum logic [1:0] {
        PH_RED    = 2'd0,
        PH_GREEN  = 2'd1,
        PH_YELLOW = 2'd2
    } phase_t;

    localparam logic [2:0] DIGIT_MAX = 3'd5;

    localparam int ROWS        = 8;
    localparam int ROW_HOLD    = 4;
    localparam int STEP_CYCLES = 64;

    // digit bitmaps, msb is the leftmost column
    // rows 0 and 5 stay dark in every digit
    localparam logic [0:5][0:7][7:0] GLYPH = '{
        '{8'h00, 8'b0011_1100, 8'b0110_0110, 8'b0110_0110,
          8'b0110_0110, 8'h00, 8'b0110_0110, 8'b0011_1100},
        '{8'h00, 8'b0001_1000, 8'b0011_1000, 8'b0001_1000,
          8'b0001_1000, 8'h00, 8'b0001_1000, 8'b0111_1110},
        '{8'h00, 8'b0011_1100, 8'b0110_0110, 8'b0000_0110,
          8'b0000_1100, 8'h00, 8'b0011_0000, 8'b0111_1110},
        '{8'h00, 8'b0011_1100, 8'b0110_0110, 8'b0000_1100,
          8'b0000_0110, 8'h00, 8'b0110_0110, 8'b0011_1100},
        '{8'h00, 8'b0000_1100, 8'b0001_1100, 8'b0011_1100,
          8'b0110_1100, 8'h00, 8'b0111_1110, 8'b0000_1100},
        '{8'h00, 8'b0111_1110, 8'b0110_0000, 8'b0111_1100,
          8'b0000_0110, 8'h00, 8'b0110_0110, 8'b0011_1100}
    };

endpackage

`default_nettype wire
